//--- src/core_pkg.sv
package core_pkg;

    // ####################################################################
    // Sizes.
    // ####################################################################

    localparam int BANK_NUM  = 2;
    localparam int BANK_SIZE = 4;
    localparam int PREG_NUM  = 64;
    localparam int RD_PORTS  = 2 * BANK_NUM;
    // Current and previous-cycle wakeups of every lane.
    localparam int WAKE_NUM  = 2 * BANK_NUM;

    localparam int PREG_W = $clog2(PREG_NUM);
    localparam int ROB_W  = 6;
    localparam int XLEN   = 32;
    localparam int OCC_W  = $clog2(BANK_SIZE + 1);
    localparam int BANK_W = $clog2(BANK_NUM);
    localparam int OP_W   = 8;

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;
    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [OCC_W-1:0]  occ_t;
    typedef logic [BANK_W-1:0] bank_id_t;
    typedef logic [OP_W-1:0]   opcode_t;

    // ####################################################################
    // Micro-op and issue packets.
    // ####################################################################

    typedef struct packed {
        rob_idx_t rob_idx;
        preg_t    rd;
        logic     rd_we;
        preg_t    rs1;
        preg_t    rs2;
        logic     rs1_ready;
        logic     rs2_ready;
        opcode_t  opcode;
    } uop_t;

    typedef struct packed {
        uop_t  uop;
        xlen_t rs1_data;
        xlen_t rs2_data;
    } issue_pkt_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } redirect_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
    } wakeup_t;

    // True when a is younger than b in the wrapping ROB order.
    function automatic logic is_younger(rob_idx_t a, rob_idx_t b);
        logic same_wrap;
        logic a_above;
        same_wrap = (a[ROB_W-1] == b[ROB_W-1]);
        a_above   = (a[ROB_W-2:0] > b[ROB_W-2:0]);
        return same_wrap ? a_above : (a[ROB_W-2:0] < b[ROB_W-2:0]);
    endfunction

endpackage

//--- src/iq_cfg_pkg.sv
package iq_cfg_pkg;

    localparam int CFG_AW = 1;
    localparam int CFG_DW = 32;

    typedef logic [CFG_AW-1:0] cfg_addr_t;

    // Register map.
    localparam cfg_addr_t CFG_ADDR_PAUSE = 1'b0;
    localparam cfg_addr_t CFG_ADDR_COUNT = 1'b1;

    // One pause bit per bank.
    typedef logic [core_pkg::BANK_NUM-1:0] pause_mask_t;

    typedef struct packed {
        logic              we;
        cfg_addr_t         addr;
        logic [CFG_DW-1:0] wdata;
    } cfg_bus_t;

endpackage

//--- src/issue_bank.sv
`timescale 1ns/1ps

module issue_bank (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alloc_en,
    input  core_pkg::uop_t      alloc_uop,
    input  core_pkg::wakeup_t   wakeup [core_pkg::WAKE_NUM],
    input  core_pkg::redirect_t redirect,
    input  logic                pause,
    output logic                full,
    output core_pkg::occ_t      occupancy,
    output logic                sel_valid,
    output core_pkg::uop_t      sel_uop
);

    localparam int IDX_W = $clog2(core_pkg::BANK_SIZE);

    logic [core_pkg::BANK_SIZE-1:0] entry_valid;
    core_pkg::uop_t                 entry_uop [core_pkg::BANK_SIZE];

    logic [core_pkg::BANK_SIZE-1:0] rs1_hit;
    logic [core_pkg::BANK_SIZE-1:0] rs2_hit;
    logic [core_pkg::BANK_SIZE-1:0] ready;
    logic [core_pkg::BANK_SIZE-1:0] kill;
    logic                           alloc_rs1_hit;
    logic                           alloc_rs2_hit;
    logic                           alloc_kill;
    logic [IDX_W-1:0]               alloc_idx;
    logic [IDX_W-1:0]               sel_idx;
    logic                           sel_found;

    // ####################################################################
    // Wakeup and redirect.
    // ####################################################################

    always_comb begin
        rs1_hit       = '0;
        rs2_hit       = '0;
        alloc_rs1_hit = 1'b0;
        alloc_rs2_hit = 1'b0;
        for (int w = 0; w < core_pkg::WAKE_NUM; w++) begin
            if (wakeup[w].valid) begin
                for (int i = 0; i < core_pkg::BANK_SIZE; i++) begin
                    if (entry_uop[i].rs1 == wakeup[w].preg) begin
                        rs1_hit[i] = 1'b1;
                    end
                    if (entry_uop[i].rs2 == wakeup[w].preg) begin
                        rs2_hit[i] = 1'b1;
                    end
                end
                if (alloc_uop.rs1 == wakeup[w].preg) begin
                    alloc_rs1_hit = 1'b1;
                end
                if (alloc_uop.rs2 == wakeup[w].preg) begin
                    alloc_rs2_hit = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < core_pkg::BANK_SIZE; i++) begin
            ready[i] = entry_valid[i] & entry_uop[i].rs1_ready & entry_uop[i].rs2_ready;
            kill[i]  = redirect.valid
                     & core_pkg::is_younger(entry_uop[i].rob_idx, redirect.rob_idx);
        end
    end

    assign alloc_kill = redirect.valid & core_pkg::is_younger(alloc_uop.rob_idx, redirect.rob_idx);

    // ####################################################################
    // Allocation and oldest-ready select.
    // ####################################################################

    always_comb begin
        alloc_idx = '0;
        for (int i = core_pkg::BANK_SIZE - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                alloc_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < core_pkg::BANK_SIZE; i++) begin
            if (ready[i] && (!sel_found ||
                core_pkg::is_younger(entry_uop[sel_idx].rob_idx, entry_uop[i].rob_idx))) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    assign sel_valid = sel_found & ~pause;
    assign sel_uop   = entry_uop[sel_idx];

    always_comb begin
        occupancy = '0;
        for (int i = 0; i < core_pkg::BANK_SIZE; i++) begin
            occupancy = occupancy + core_pkg::occ_t'(entry_valid[i]);
        end
    end

    assign full = &entry_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else begin
            for (int i = 0; i < core_pkg::BANK_SIZE; i++) begin
                if (kill[i] || (sel_valid && sel_idx == IDX_W'(i))) begin
                    entry_valid[i] <= 1'b0;
                end
            end
            // The allocated entry is free, so it never collides with the select.
            if (alloc_en && !alloc_kill) begin
                entry_valid[alloc_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < core_pkg::BANK_SIZE; i++) begin
            if (alloc_en && alloc_idx == IDX_W'(i)) begin
                entry_uop[i]           <= alloc_uop;
                entry_uop[i].rs1_ready <= alloc_uop.rs1_ready | alloc_rs1_hit;
                entry_uop[i].rs2_ready <= alloc_uop.rs2_ready | alloc_rs2_hit;
            end else begin
                if (rs1_hit[i]) begin
                    entry_uop[i].rs1_ready <= 1'b1;
                end
                if (rs2_hit[i]) begin
                    entry_uop[i].rs2_ready <= 1'b1;
                end
            end
        end
    end

endmodule

//--- src/bank_order_selector.sv
`timescale 1ns/1ps

module bank_order_selector (
    input  core_pkg::occ_t     occupancy [core_pkg::BANK_NUM],
    output core_pkg::bank_id_t order     [core_pkg::BANK_NUM]
);

    core_pkg::bank_id_t least;

    // Least occupied bank, ties going to the lower number.
    always_comb begin
        least = '0;
        for (int b = 1; b < core_pkg::BANK_NUM; b++) begin
            if (occupancy[b] < occupancy[least]) begin
                least = core_pkg::bank_id_t'(b);
            end
        end
    end

    // Slot 0 takes the least loaded bank.
    // Later slots rotate through the remaining banks.
    always_comb begin
        for (int s = 0; s < core_pkg::BANK_NUM; s++) begin
            order[s] = least + core_pkg::bank_id_t'(s);
        end
    end

endmodule

//--- src/int_issue_queue.sv
`timescale 1ns/1ps

module int_issue_queue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [core_pkg::BANK_NUM-1:0] dispatch_valid,
    input  core_pkg::uop_t                dispatch_uop [core_pkg::BANK_NUM],
    input  core_pkg::redirect_t           redirect,
    input  iq_cfg_pkg::pause_mask_t       pause,
    input  core_pkg::xlen_t               rdata [core_pkg::RD_PORTS],
    output logic                          dispatch_full,
    output core_pkg::preg_t               raddr [core_pkg::RD_PORTS],
    output logic [core_pkg::BANK_NUM-1:0] issue_valid,
    output core_pkg::issue_pkt_t          issue_pkt [core_pkg::BANK_NUM]
);

    logic [core_pkg::BANK_NUM-1:0] bank_full;
    logic [core_pkg::BANK_NUM-1:0] alloc_en;
    core_pkg::uop_t                alloc_uop [core_pkg::BANK_NUM];
    core_pkg::occ_t                occupancy [core_pkg::BANK_NUM];
    core_pkg::bank_id_t            order     [core_pkg::BANK_NUM];
    logic [core_pkg::BANK_NUM-1:0] sel_valid;
    core_pkg::uop_t                sel_uop   [core_pkg::BANK_NUM];
    logic [core_pkg::BANK_NUM-1:0] sel_kill;
    core_pkg::wakeup_t             wake_cur  [core_pkg::BANK_NUM];
    core_pkg::wakeup_t             wake_prev [core_pkg::BANK_NUM];
    core_pkg::wakeup_t             wake_all  [core_pkg::WAKE_NUM];

    bank_order_selector u_order (
        .occupancy (occupancy),
        .order     (order)
    );

    // ####################################################################
    // Dispatch steering.
    // ####################################################################

    always_comb begin
        for (int b = 0; b < core_pkg::BANK_NUM; b++) begin
            alloc_en[b]  = 1'b0;
            alloc_uop[b] = dispatch_uop[0];
        end
        for (int s = 0; s < core_pkg::BANK_NUM; s++) begin
            for (int b = 0; b < core_pkg::BANK_NUM; b++) begin
                if (order[s] == core_pkg::bank_id_t'(b)) begin
                    alloc_en[b]  = dispatch_valid[s] & ~dispatch_full;
                    alloc_uop[b] = dispatch_uop[s];
                end
            end
        end
    end

    assign dispatch_full = |bank_full;

    // ####################################################################
    // Banks, wakeup lanes and register reads.
    // ####################################################################

    for (genvar b = 0; b < core_pkg::BANK_NUM; b++) begin : g_bank
        issue_bank u_bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .alloc_en  (alloc_en[b]),
            .alloc_uop (alloc_uop[b]),
            .wakeup    (wake_all),
            .redirect  (redirect),
            .pause     (pause[b]),
            .full      (bank_full[b]),
            .occupancy (occupancy[b]),
            .sel_valid (sel_valid[b]),
            .sel_uop   (sel_uop[b])
        );

        assign wake_cur[b].valid = sel_valid[b] & sel_uop[b].rd_we;
        assign wake_cur[b].preg  = sel_uop[b].rd;

        // Lanes first, then last cycle's copies for late dispatches.
        assign wake_all[b]                      = wake_cur[b];
        assign wake_all[core_pkg::BANK_NUM + b] = wake_prev[b];

        assign raddr[b]                      = sel_uop[b].rs1;
        assign raddr[core_pkg::BANK_NUM + b] = sel_uop[b].rs2;

        assign sel_kill[b] = redirect.valid
                           & core_pkg::is_younger(sel_uop[b].rob_idx, redirect.rob_idx);
    end

    // ####################################################################
    // Issue register.
    // ####################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= '0;
            for (int b = 0; b < core_pkg::BANK_NUM; b++) begin
                wake_prev[b] <= '0;
            end
        end else begin
            issue_valid <= sel_valid & ~sel_kill;
            for (int b = 0; b < core_pkg::BANK_NUM; b++) begin
                wake_prev[b] <= wake_cur[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < core_pkg::BANK_NUM; b++) begin
            issue_pkt[b].uop      <= sel_uop[b];
            issue_pkt[b].rs1_data <= rdata[b];
            issue_pkt[b].rs2_data <= rdata[core_pkg::BANK_NUM + b];
        end
    end

endmodule

//--- src/iq_config_regs.sv
`timescale 1ns/1ps

module iq_config_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  iq_cfg_pkg::cfg_bus_t          cfg,
    input  logic [core_pkg::BANK_NUM-1:0] issue_valid,
    output core_pkg::xlen_t               cfg_rdata,
    output iq_cfg_pkg::pause_mask_t       pause
);

    core_pkg::xlen_t count;
    core_pkg::xlen_t issued_now;

    always_comb begin
        issued_now = '0;
        for (int b = 0; b < core_pkg::BANK_NUM; b++) begin
            issued_now = issued_now + core_pkg::xlen_t'(issue_valid[b]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pause <= '0;
            count <= '0;
        end else begin
            if (cfg.we && cfg.addr == iq_cfg_pkg::CFG_ADDR_PAUSE) begin
                pause <= cfg.wdata[core_pkg::BANK_NUM-1:0];
            end
            // Any write to the count register clears it.
            if (cfg.we && cfg.addr == iq_cfg_pkg::CFG_ADDR_COUNT) begin
                count <= '0;
            end else begin
                count <= count + issued_now;
            end
        end
    end

    assign cfg_rdata = (cfg.addr == iq_cfg_pkg::CFG_ADDR_PAUSE) ? core_pkg::xlen_t'(pause)
                                                                : count;

endmodule

//--- src/int_regfile.sv
`timescale 1ns/1ps

module int_regfile (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wb_en,
    input  core_pkg::preg_t wb_preg,
    input  core_pkg::xlen_t wb_data,
    input  core_pkg::preg_t raddr [core_pkg::RD_PORTS],
    output core_pkg::xlen_t rdata [core_pkg::RD_PORTS]
);

    core_pkg::xlen_t regs [core_pkg::PREG_NUM];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < core_pkg::PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_preg] <= wb_data;
        end
    end

    // Reads see the array as of the last edge, with no bypass.
    always_comb begin
        for (int p = 0; p < core_pkg::RD_PORTS; p++) begin
            rdata[p] = regs[raddr[p]];
        end
    end

endmodule

//--- src/iq_top.sv
`timescale 1ns/1ps

module iq_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [core_pkg::BANK_NUM-1:0] dispatch_valid,
    input  core_pkg::uop_t                dispatch_uop [core_pkg::BANK_NUM],
    output logic                          dispatch_full,
    input  core_pkg::redirect_t           redirect,
    input  logic                          wb_en,
    input  core_pkg::preg_t               wb_preg,
    input  core_pkg::xlen_t               wb_data,
    input  iq_cfg_pkg::cfg_bus_t          cfg,
    output core_pkg::xlen_t               cfg_rdata,
    output logic [core_pkg::BANK_NUM-1:0] issue_valid,
    output core_pkg::issue_pkt_t          issue_pkt [core_pkg::BANK_NUM]
);

    core_pkg::preg_t         raddr [core_pkg::RD_PORTS];
    core_pkg::xlen_t         rdata [core_pkg::RD_PORTS];
    iq_cfg_pkg::pause_mask_t pause;

    int_issue_queue u_iq (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .redirect       (redirect),
        .pause          (pause),
        .rdata          (rdata),
        .dispatch_full  (dispatch_full),
        .raddr          (raddr),
        .issue_valid    (issue_valid),
        .issue_pkt      (issue_pkt)
    );

    int_regfile u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_en   (wb_en),
        .wb_preg (wb_preg),
        .wb_data (wb_data),
        .raddr   (raddr),
        .rdata   (rdata)
    );

    iq_config_regs u_cfg (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .issue_valid (issue_valid),
        .cfg_rdata   (cfg_rdata),
        .pause       (pause)
    );

endmodule

//--- bench/tb_iq_model.svh
`ifndef TB_IQ_MODEL_SVH
`define TB_IQ_MODEL_SVH

// ######################################################################
// Reference model helpers.
// ######################################################################

// Fibonacci LFSR with taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// Takes n bits, one LFSR step per bit.
function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// True when ROB index a is younger than b.
function automatic logic ref_younger(logic [5:0] a, logic [5:0] b);
    if (a[5] == b[5]) begin
        return a[4:0] > b[4:0];
    end
    return a[4:0] < b[4:0];
endfunction

// Slot 0 goes to the emptier bank, ties to bank 0; slot 1 to the other.
function automatic int ref_bank(int slot, int occ0, int occ1);
    int least;
    least = (occ1 < occ0) ? 1 : 0;
    return (slot == 0) ? least : 1 - least;
endfunction

// Register file contents as preloaded.
function automatic logic [31:0] ref_operand(logic [5:0] preg);
    return rf_model[preg];
endfunction

`endif

//--- bench/tb_iq_top.sv
`timescale 1ns/1ps

module tb_iq_top;

    logic                    clk;
    logic                    rst_n;
    logic [1:0]              dispatch_valid;
    core_pkg::uop_t          dispatch_uop [2];
    logic                    dispatch_full;
    core_pkg::redirect_t     redirect;
    logic                    wb_en;
    core_pkg::preg_t         wb_preg;
    core_pkg::xlen_t         wb_data;
    iq_cfg_pkg::cfg_bus_t    cfg;
    core_pkg::xlen_t         cfg_rdata;
    logic [1:0]              issue_valid;
    core_pkg::issue_pkt_t    issue_pkt [2];

    // Model state, indexed by ROB index or register number.
    logic [31:0]     lfsr_state;
    core_pkg::xlen_t rf_model [64];
    int              st [64];
    int              bank_of [64];
    core_pkg::uop_t  uop_of [64];
    int              prod1 [64];
    int              prod2 [64];
    int              issue_cyc [64];
    logic            live [64];
    int              prod_rob [64];
    int              stamp [64];
    logic [1:0]      pause_model;
    logic [5:0]      next_rob;
    logic            chain_mode;
    logic            saw_full;
    core_pkg::preg_t chain_rd;
    int              cycle;
    int              n_disp;
    int              model_count;
    int              mism_errs;
    int              other_errs;
    int              watch;

    `include "tb_iq_model.svh"

    iq_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_full  (dispatch_full),
        .redirect       (redirect),
        .wb_en          (wb_en),
        .wb_preg        (wb_preg),
        .wb_data        (wb_data),
        .cfg            (cfg),
        .cfg_rdata      (cfg_rdata),
        .issue_valid    (issue_valid),
        .issue_pkt      (issue_pkt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic int occ(int b);
        int n;
        n = 0;
        for (int r = 0; r < 64; r++) begin
            if (st[r] == 1 && bank_of[r] == b) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic pick_rd(output logic ok, output core_pkg::preg_t rd);
        core_pkg::preg_t r;
        ok = 1'b0;
        rd = '0;
        for (int t = 0; t < 8; t++) begin
            r = core_pkg::preg_t'(take_bits(6));
            if (!ok && !live[r] && cycle > stamp[r] + 3) begin
                ok = 1'b1;
                rd = r;
            end
        end
    endtask

    // Builds one accepted uop and records it in the model.
    task automatic accept_uop(input int b, output core_pkg::uop_t u);
        logic ok;
        core_pkg::preg_t rd;
        u.rob_idx   = next_rob;
        u.opcode    = core_pkg::opcode_t'(take_bits(8));
        u.rs1       = chain_mode ? chain_rd : core_pkg::preg_t'(take_bits(6));
        u.rs2       = core_pkg::preg_t'(take_bits(6));
        u.rs1_ready = !live[u.rs1];
        u.rs2_ready = !live[u.rs2];
        prod1[next_rob] = live[u.rs1] ? prod_rob[u.rs1] : -1;
        prod2[next_rob] = live[u.rs2] ? prod_rob[u.rs2] : -1;
        pick_rd(ok, rd);
        u.rd    = rd;
        u.rd_we = ok;
        if (ok) begin
            live[rd]     = 1'b1;
            prod_rob[rd] = int'(next_rob);
            chain_rd     = rd;
        end
        st[next_rob]      = 1;
        bank_of[next_rob] = b;
        uop_of[next_rob]  = u;
        next_rob          = next_rob + 6'd1;
        n_disp++;
    endtask

    // Called at a falling edge; drives n slots for the next rising edge.
    task automatic dispatch_cycle(input int n);
        int o0;
        int o1;
        logic mfull;
        core_pkg::uop_t u;
        o0 = occ(0);
        o1 = occ(1);
        mfull = (o0 == 4) || (o1 == 4);
        assert (dispatch_full == mfull) else begin
            mism_errs++;
            $display("Mismatch dispatch_full: dut %h model %h", dispatch_full, mfull);
        end
        for (int s = 0; s < n; s++) begin
            if (mfull) begin
                // Held slots must not be taken.
                dispatch_uop[s].rob_idx = next_rob + 6'(s);
            end else begin
                accept_uop(ref_bank(s, o0, o1), u);
                dispatch_uop[s] = u;
            end
        end
        if (mfull) begin
            saw_full = 1'b1;
        end
        dispatch_valid = (n == 2) ? 2'b11 : 2'b01;
    endtask

    task automatic run_stream(input int cycles);
        for (int k = 0; k < cycles; k++) begin
            dispatch_cycle(1 + int'(take_bits(1)));
            @(negedge clk);
        end
        dispatch_valid = 2'b00;
    endtask

    function automatic int pending_count();
        int n;
        n = 0;
        for (int r = 0; r < 64; r++) begin
            if (st[r] == 1) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic drain();
        while (pending_count() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic send_redirect();
        logic [5:0] point;
        point = next_rob - 6'd3 - 6'(take_bits(2));
        dispatch_valid = 2'b00;
        redirect.valid   = 1'b1;
        redirect.rob_idx = point;
        // The kill covers the uop selected in this cycle as well.
        for (int r = 0; r < 64; r++) begin
            if (st[r] == 1 && ref_younger(6'(r), point)) begin
                st[r] = 2;
                if (uop_of[r].rd_we) begin
                    live[uop_of[r].rd]  = 1'b0;
                    stamp[uop_of[r].rd] = cycle;
                end
            end
        end
        @(negedge clk);
        redirect.valid = 1'b0;
    endtask

    task automatic write_cfg(input logic addr, input logic [31:0] data);
        cfg.we    = 1'b1;
        cfg.addr  = addr;
        cfg.wdata = data;
        @(negedge clk);
        cfg.we = 1'b0;
        if (addr == iq_cfg_pkg::CFG_ADDR_PAUSE) begin
            pause_model = data[1:0];
        end else begin
            model_count = 0;
        end
    endtask

    // ##################################################################
    // Issue checks, just after each rising edge.
    // ##################################################################

    task automatic check_issue(input int b);
        logic [5:0] r;
        core_pkg::uop_t got;
        got = issue_pkt[b].uop;
        r   = got.rob_idx;
        model_count++;
        assert (!pause_model[b]) else begin
            other_errs++;
            $display("Lane %0d issued while its bank was paused", b);
        end
        assert (st[r] == 1) else begin
            other_errs++;
            $display("Lane %0d issued rob %h which is not waiting in the queue", b, r);
        end
        if (st[r] == 1) begin
            assert (bank_of[r] == b) else begin
                mism_errs++;
                $display("Mismatch issue_valid lane: rob %h got %h exp %h", r, b, bank_of[r]);
            end
            // An issued uop has both sources ready.
            assert ({got.rd, got.rd_we, got.rs1, got.rs2, got.rs1_ready, got.rs2_ready,
                     got.opcode} ==
                    {uop_of[r].rd, uop_of[r].rd_we, uop_of[r].rs1, uop_of[r].rs2, 1'b1, 1'b1,
                     uop_of[r].opcode}) else begin
                mism_errs++;
                $display("Mismatch issue_pkt.uop: got %h exp %h", got, uop_of[r]);
            end
            assert (issue_pkt[b].rs1_data == ref_operand(got.rs1)) else begin
                mism_errs++;
                $display("Mismatch rs1_data: got %h exp %h", issue_pkt[b].rs1_data,
                         ref_operand(got.rs1));
            end
            assert (issue_pkt[b].rs2_data == ref_operand(got.rs2)) else begin
                mism_errs++;
                $display("Mismatch rs2_data: got %h exp %h", issue_pkt[b].rs2_data,
                         ref_operand(got.rs2));
            end
            if (prod1[r] >= 0) begin
                assert (st[prod1[r]] == 3 && issue_cyc[prod1[r]] < cycle) else begin
                    other_errs++;
                    $display("Rob %h issued before its rs1 producer rob %h", r, prod1[r]);
                end
            end
            if (prod2[r] >= 0) begin
                assert (st[prod2[r]] == 3 && issue_cyc[prod2[r]] < cycle) else begin
                    other_errs++;
                    $display("Rob %h issued before its rs2 producer rob %h", r, prod2[r]);
                end
            end
            st[r]        = 3;
            issue_cyc[r] = cycle;
            if (uop_of[r].rd_we) begin
                live[uop_of[r].rd]  = 1'b0;
                stamp[uop_of[r].rd] = cycle;
            end
        end
    endtask

    always @(posedge clk) begin
        #1;
        if (rst_n) begin
            cycle++;
            for (int b = 0; b < 2; b++) begin
                if (issue_valid[b]) begin
                    check_issue(b);
                end
            end
        end
    end

    // Watchdog, scaled by the number of dispatched uops.
    initial begin
        watch = 0;
        while (watch <= 20 * n_disp + 2000) begin
            @(posedge clk);
            watch++;
        end
        $display("Timeout after %0d cycles with %0d uops still waiting", watch, pending_count());
        $display("Mismatch errors %0d, other errors %0d", mism_errs, other_errs + 1);
        $display("ERRORS FOUND");
        $finish;
    end

    // ##################################################################
    // Stimulus.
    // ##################################################################

    initial begin
        rst_n          = 1'b0;
        dispatch_valid = 2'b00;
        dispatch_uop[0] = '0;
        dispatch_uop[1] = '0;
        redirect       = '0;
        wb_en          = 1'b0;
        wb_preg        = '0;
        wb_data        = '0;
        cfg            = '0;
        lfsr_state     = 32'hf7a;
        pause_model    = 2'b00;
        next_rob       = '0;
        chain_mode     = 1'b0;
        chain_rd       = '0;
        saw_full       = 1'b0;
        cycle          = 0;
        n_disp         = 0;
        model_count    = 0;
        mism_errs      = 0;
        other_errs     = 0;
        for (int i = 0; i < 64; i++) begin
            st[i]    = 0;
            live[i]  = 1'b0;
            stamp[i] = -100;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 64; i++) begin
            wb_en       = 1'b1;
            wb_preg     = core_pkg::preg_t'(i);
            wb_data     = take_bits(32);
            rf_model[i] = wb_data;
            @(negedge clk);
        end
        wb_en = 1'b0;
        write_cfg(iq_cfg_pkg::CFG_ADDR_COUNT, 32'h0);

        run_stream(60);
        drain();

        run_stream(6);
        send_redirect();
        run_stream(10);
        drain();

        saw_full   = 1'b0;
        chain_mode = 1'b1;
        run_stream(30);
        chain_mode = 1'b0;
        drain();
        assert (saw_full) else begin
            other_errs++;
            $display("dispatch_full never rose during the dependency chain");
        end

        // Clear a count that is no longer zero.
        write_cfg(iq_cfg_pkg::CFG_ADDR_COUNT, 32'h5a5a);

        write_cfg(iq_cfg_pkg::CFG_ADDR_PAUSE, 32'h2);
        assert (cfg_rdata == core_pkg::xlen_t'(pause_model)) else begin
            mism_errs++;
            $display("Mismatch cfg_rdata: got %h exp %h", cfg_rdata, pause_model);
        end
        run_stream(16);
        repeat (6) @(negedge clk);
        write_cfg(iq_cfg_pkg::CFG_ADDR_PAUSE, 32'h0);
        drain();

        cfg.addr = iq_cfg_pkg::CFG_ADDR_COUNT;
        @(negedge clk);
        assert (cfg_rdata == core_pkg::xlen_t'(model_count)) else begin
            mism_errs++;
            $display("Mismatch cfg_rdata: got %h exp %h", cfg_rdata, model_count);
        end
        for (int r = 0; r < 64; r++) begin
            assert (st[r] != 1) else begin
                other_errs++;
                $display("Rob %h was accepted but never issued", r);
            end
        end

        $display("Mismatch errors %0d, other errors %0d", mism_errs, other_errs);
        if (mism_errs + other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+bench
src/core_pkg.sv
src/iq_cfg_pkg.sv
src/issue_bank.sv
src/bank_order_selector.sv
src/int_issue_queue.sv
src/iq_config_regs.sv
src/int_regfile.sv
src/iq_top.sv
bench/tb_iq_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_iq_top -f compile.f &&
./obj_dir/Vtb_iq_top | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
